/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fdc
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* fdc_host_port.sv */
`timescale 1ns/1ps

module fdc_host_port
	import fdc_pkg::*;
(
	input  logic                  i_clk_sys,
	input  logic                  i_reset,
	input  logic                  i_a0,
	input  logic                  i_rd_n,
	input  logic                  i_wr_n,
	input  fdc_byte_t             i_din,
	output fdc_byte_t             o_dout,
	output host_wr_t              o_host_wr,
	output logic                  o_rd_pulse,
	input  fdc_byte_t             i_fifo_head,
	input  logic                  i_fifo_not_empty,
	input  logic                  i_busy,
	input  logic [NUM_DRIVES-1:0] i_seeking
);

// sampled bus
logic      rd_q, wr_q;
logic      rd_d, wr_d;  // previous sample for edge detection
logic      a0_q;
fdc_byte_t din_q;

logic      rd_edge, wr_edge;
fdc_byte_t msr;

// a strobe counts only while the other one is idle
assign rd_edge = rd_q & ~rd_d;
assign wr_edge = wr_q & ~wr_d;

// ====================
// main status register
always_comb begin
	msr                      = '0;
	msr[NUM_DRIVES-1:0]      = i_seeking;
	msr[MSR_BUSY]            = i_busy;
	msr[MSR_DIO]             = i_fifo_not_empty;       // result byte waiting
	msr[MSR_RQM]             = i_fifo_not_empty | ~i_busy;
end

always_ff @(posedge i_clk_sys) begin
	if (i_reset) begin
		rd_q            <= 1'b0;
		wr_q            <= 1'b0;
		rd_d            <= 1'b0;
		wr_d            <= 1'b0;
		o_host_wr.valid <= 1'b0;
		o_rd_pulse      <= 1'b0;
	end else begin
		rd_q  <= ~i_rd_n & i_wr_n;
		wr_q  <= ~i_wr_n & i_rd_n;
		rd_d  <= rd_q;
		wr_d  <= wr_q;
		a0_q  <= i_a0;
		din_q <= i_din;

		// write to the data register goes to the sequencer
		o_host_wr.valid <= wr_edge & a0_q;
		o_host_wr.data  <= din_q;

		o_rd_pulse <= rd_edge & a0_q;  // pops the FIFO head

		if (rd_edge) begin
			if (!a0_q)
				o_dout <= msr;
			else if (i_fifo_not_empty)
				o_dout <= i_fifo_head;
			else
				o_dout <= '1;  // nothing queued
		end
	end
end

endmodule

/* fdc_pkg.sv */
package fdc_pkg;

// ====================
// sizes and limits
localparam int BYTE_W     = 8;
localparam int NUM_DRIVES = 2;
localparam int MAX_CYL    = 80;  // seek targets must stay below this
localparam int FIFO_DEPTH = 8;   // result entries, also the initial credit
localparam int SRT_W      = 4;
localparam int STEP_SLOTS = 16;  // step period is STEP_SLOTS - srt in ms

localparam int DRV_W = $clog2(NUM_DRIVES);
localparam int PTR_W = $clog2(FIFO_DEPTH);
localparam int CRD_W = $clog2(FIFO_DEPTH + 1);
localparam int CMD_W = 5;

// ====================
// command codes, low five bits of the first byte
localparam logic [CMD_W-1:0] CMD_SPECIFY     = 5'd3;
localparam logic [CMD_W-1:0] CMD_SENSE_DRIVE = 5'd4;
localparam logic [CMD_W-1:0] CMD_RECAL       = 5'd7;
localparam logic [CMD_W-1:0] CMD_SENSE_INT   = 5'd8;
localparam logic [CMD_W-1:0] CMD_SEEK        = 5'd15;

// main status register, bits 0/1 carry the per-drive seek flags
localparam int MSR_BUSY = 4;
localparam int MSR_DIO  = 6;
localparam int MSR_RQM  = 7;

// ST3 fields of SENSE DRIVE STATUS
localparam int ST3_WP       = 6;
localparam int ST3_READY    = 5;
localparam int ST3_TRACK0   = 4;
localparam int ST3_TWO_SIDE = 3;
localparam int ST3_HEAD     = 2;
localparam int HEAD_BIT     = 2;  // head select in the drive parameter byte

localparam logic [BYTE_W-1:0] ST0_SEEK_END  = 8'h20;
localparam logic [BYTE_W-1:0] ST0_SEEK_FAIL = 8'hE8;
localparam logic [BYTE_W-1:0] ST0_INVALID   = 8'h80;

// ====================
typedef logic [BYTE_W-1:0] fdc_byte_t;

typedef struct packed {
	logic      valid;  // one cycle per data register write
	fdc_byte_t data;
} host_wr_t;

typedef struct packed {
	logic             valid;
	logic [DRV_W-1:0] drive;
	logic             recal;  // target forced to track 0
	fdc_byte_t        cyl;
} seek_req_t;

typedef struct packed {
	fdc_byte_t pcn;        // present cylinder
	logic      seeking;
	logic      int_pend;
	logic      at_target;  // pcn equals ncn
	logic      ready;
} drive_stat_t;

typedef struct packed {
	logic      valid;
	fdc_byte_t data;
} result_t;

endpackage

/* fdc_result_fifo.sv */
`timescale 1ns/1ps

module fdc_result_fifo
	import fdc_pkg::*;
(
	input  logic      i_clk_sys,
	input  logic      i_reset,
	input  result_t   i_push,
	input  logic      i_pop,
	output fdc_byte_t o_head,
	output logic      o_not_empty,
	output logic      o_credit
);

typedef logic [PTR_W:0] cnt_t;

fdc_byte_t        mem [FIFO_DEPTH];
logic [PTR_W-1:0] wr_ptr, rd_ptr;  // depth is a power of two, pointers wrap
cnt_t             count;
logic             full;
logic             pop_ok;

assign full        = count == cnt_t'(FIFO_DEPTH);
assign o_not_empty = count != '0;
assign pop_ok      = i_pop && o_not_empty;  // read of an empty FIFO is dropped
assign o_head      = mem[rd_ptr];

always_ff @(posedge i_clk_sys) begin
	if (i_push.valid)
		mem[wr_ptr] <= i_push.data;
end

always_ff @(posedge i_clk_sys) begin
	if (i_reset) begin
		wr_ptr   <= '0;
		rd_ptr   <= '0;
		count    <= '0;
		o_credit <= 1'b0;
	end else begin
		if (i_push.valid)
			wr_ptr <= wr_ptr + 1'b1;
		if (pop_ok)
			rd_ptr <= rd_ptr + 1'b1;
		count    <= count + cnt_t'(i_push.valid) - cnt_t'(pop_ok);
		o_credit <= pop_ok;  // one credit back per byte gone
	end
end

// the sequencer's credit count keeps pushes within the depth
a_no_overflow: assert property (@(posedge i_clk_sys) disable iff (i_reset)
	i_push.valid |-> !full);

endmodule

/* fdc_seek_unit.sv */
`timescale 1ns/1ps

module fdc_seek_unit
	import fdc_pkg::*;
#(
	parameter int CYCLES_PER_MS = 4000
) (
	input  logic                         i_clk_sys,
	input  logic                         i_reset,
	input  seek_req_t                    i_seek_req,
	input  logic [NUM_DRIVES-1:0]        i_int_clear,
	input  logic [SRT_W-1:0]             i_srt,
	input  logic [NUM_DRIVES-1:0]        i_ready,
	output drive_stat_t [NUM_DRIVES-1:0] o_drive_stat
);

typedef logic [$clog2(CYCLES_PER_MS)-1:0] ms_cnt_t;
typedef logic [SRT_W:0] slot_t;

ms_cnt_t ms_cnt;
slot_t   slot_cnt;
slot_t   slot_reload;
logic    ms_tick;
logic    step_tick;

fdc_byte_t             pcn [NUM_DRIVES];
fdc_byte_t             ncn [NUM_DRIVES];
logic [NUM_DRIVES-1:0] seeking;
logic [NUM_DRIVES-1:0] int_pend;

fdc_byte_t seek_tgt;
logic      seek_ok;

// ====================
// shared step timer
assign ms_tick     = ms_cnt == ms_cnt_t'(CYCLES_PER_MS - 1);
assign slot_reload = slot_t'(STEP_SLOTS) - {1'b0, i_srt};
assign step_tick   = ms_tick && slot_cnt <= slot_t'(1);

always_ff @(posedge i_clk_sys) begin
	if (i_reset) begin
		ms_cnt   <= '0;
		slot_cnt <= slot_t'(STEP_SLOTS);
	end else begin
		ms_cnt <= ms_tick ? '0 : ms_cnt + 1'b1;
		if (ms_tick)
			slot_cnt <= (slot_cnt <= slot_t'(1)) ? slot_reload : slot_cnt - 1'b1;
	end
end

// recalibrate always heads for track 0
assign seek_tgt = i_seek_req.recal ? '0 : i_seek_req.cyl;
assign seek_ok  = (seek_tgt == '0) ||
                  (seek_tgt < BYTE_W'(MAX_CYL) && i_ready[i_seek_req.drive]);

// ====================
// per-drive head position
always_ff @(posedge i_clk_sys) begin
	if (i_reset) begin
		seeking  <= '0;
		int_pend <= '0;
		for (int i = 0; i < NUM_DRIVES; i++) begin
			pcn[i] <= '0;
			ncn[i] <= '0;
		end
	end else begin
		for (int i = 0; i < NUM_DRIVES; i++) begin
			if (i_int_clear[i])
				int_pend[i] <= 1'b0;

			if (seeking[i]) begin
				if (pcn[i] == ncn[i]) begin  // arrived
					seeking[i]  <= 1'b0;
					int_pend[i] <= 1'b1;
				end else if (step_tick) begin
					pcn[i] <= (pcn[i] > ncn[i]) ? pcn[i] - 1'b1 : pcn[i] + 1'b1;
				end
			end

			if (i_seek_req.valid && i_seek_req.drive == DRV_W'(i)) begin
				ncn[i]      <= seek_tgt;
				seeking[i]  <= seek_ok;
				int_pend[i] <= ~seek_ok;  // rejected seek ends at once
			end
		end
	end
end

for (genvar g = 0; g < NUM_DRIVES; g++) begin : g_drive
	assign o_drive_stat[g].pcn       = pcn[g];
	assign o_drive_stat[g].seeking   = seeking[g];
	assign o_drive_stat[g].int_pend  = int_pend[g];
	assign o_drive_stat[g].at_target = pcn[g] == ncn[g];
	assign o_drive_stat[g].ready     = i_ready[g];

	// head never runs past the last accepted cylinder
	a_pcn_limit: assert property (@(posedge i_clk_sys) disable iff (i_reset)
		pcn[g] <= BYTE_W'(MAX_CYL));
end

endmodule

/* fdc_sequencer.sv */
`timescale 1ns/1ps

module fdc_sequencer
	import fdc_pkg::*;
(
	input  logic                         i_clk_sys,
	input  logic                         i_reset,
	input  host_wr_t                     i_host_wr,
	output seek_req_t                    o_seek_req,
	output logic [NUM_DRIVES-1:0]        o_int_clear,
	output logic [SRT_W-1:0]             o_srt,
	input  drive_stat_t [NUM_DRIVES-1:0] i_drive_stat,
	input  logic                         i_wp,
	input  logic [NUM_DRIVES-1:0]        i_two_sided,
	output result_t                      o_result,
	input  logic                         i_credit,
	output logic                         o_busy
);

typedef enum logic [1:0] {
	ST_IDLE,
	ST_PARAM,
	ST_RESULT
} state_t;

state_t           state;
logic [CMD_W-1:0] cmd_q;
logic [1:0]       param_left;
fdc_byte_t        param0;     // first of two parameter bytes
logic [CRD_W-1:0] credit;
fdc_byte_t        res0_q, res1_q;
logic             res_two;    // result phase has two bytes
logic             res_idx;

logic [CMD_W-1:0] cmd_now;
logic [1:0]       n_param;
logic             last_byte;
logic             has_result;
logic [DRV_W-1:0] drv;
logic [DRV_W-1:0] int_drv;
logic             int_any;
fdc_byte_t        st0_int;
fdc_byte_t        drv_st3;
fdc_byte_t        res0_now;
logic [CRD_W-1:0] res_need;
logic             push;

// the command byte itself is decoded before it is latched
assign cmd_now   = (state == ST_IDLE) ? i_host_wr.data[CMD_W-1:0] : cmd_q;
assign last_byte = i_host_wr.valid &&
                   ((state == ST_IDLE && n_param == 2'd0) ||
                    (state == ST_PARAM && param_left == 2'd1));
assign drv       = i_host_wr.data[DRV_W-1:0];

// ====================
// result bytes
always_comb begin
	int_any = 1'b0;
	int_drv = '0;
	for (int i = NUM_DRIVES - 1; i >= 0; i--) begin
		if (i_drive_stat[i].int_pend) begin  // lowest pending drive wins
			int_any = 1'b1;
			int_drv = DRV_W'(i);
		end
	end
end

always_comb begin
	st0_int = (i_drive_stat[int_drv].at_target && i_drive_stat[int_drv].ready) ?
	          ST0_SEEK_END : ST0_SEEK_FAIL;
	st0_int[DRV_W-1:0] = int_drv;
end

always_comb begin
	drv_st3                = '0;
	drv_st3[ST3_WP]        = i_wp & i_drive_stat[drv].ready;
	drv_st3[ST3_READY]     = i_drive_stat[drv].ready;
	drv_st3[ST3_TRACK0]    = i_drive_stat[drv].pcn == '0;
	drv_st3[ST3_TWO_SIDE]  = i_two_sided[drv];
	drv_st3[ST3_HEAD]      = i_host_wr.data[HEAD_BIT];
	drv_st3[DRV_W-1:0]     = drv;
end

always_comb begin
	n_param    = 2'd0;
	has_result = 1'b1;
	res0_now   = ST0_INVALID;  // also the unknown-command answer
	case (cmd_now)
		CMD_SPECIFY: begin
			n_param    = 2'd2;
			has_result = 1'b0;
		end
		CMD_SEEK: begin
			n_param    = 2'd2;
			has_result = 1'b0;
		end
		CMD_RECAL: begin
			n_param    = 2'd1;
			has_result = 1'b0;
		end
		CMD_SENSE_DRIVE: begin
			n_param  = 2'd1;
			res0_now = drv_st3;
		end
		CMD_SENSE_INT: begin
			if (int_any)
				res0_now = st0_int;
		end
		default: ;
	endcase
end

// a phase starts only when every one of its bytes has a credit
assign res_need = res_two ? CRD_W'(2) : CRD_W'(1);
assign push     = (state == ST_RESULT) && (res_idx || credit >= res_need);
assign o_busy   = (state == ST_RESULT);  // no byte accepted here

// ====================
always_ff @(posedge i_clk_sys) begin
	if (i_reset) begin
		state            <= ST_IDLE;
		cmd_q            <= '0;
		param_left       <= '0;
		res_two          <= 1'b0;
		res_idx          <= 1'b0;
		credit           <= CRD_W'(FIFO_DEPTH);
		o_srt            <= '0;
		o_int_clear      <= '0;
		o_seek_req.valid <= 1'b0;
		o_result.valid   <= 1'b0;
	end else begin
		o_seek_req.valid <= 1'b0;
		o_int_clear      <= '0;
		o_result.valid   <= push;
		o_result.data    <= res_idx ? res1_q : res0_q;
		credit           <= credit + CRD_W'(i_credit) - CRD_W'(push);

		case (state)
			ST_IDLE: begin
				if (i_host_wr.valid) begin
					cmd_q      <= cmd_now;
					param_left <= n_param;
					if (n_param != 2'd0)
						state <= ST_PARAM;
				end
			end
			ST_PARAM: begin
				if (i_host_wr.valid) begin
					param_left <= param_left - 2'd1;
					if (!last_byte)
						param0 <= i_host_wr.data;
				end
			end
			ST_RESULT: begin
				if (push) begin
					if (res_idx == res_two) begin
						res_idx <= 1'b0;
						state   <= ST_IDLE;
					end else begin
						res_idx <= 1'b1;
					end
				end
			end
			default: state <= ST_IDLE;
		endcase

		// command complete, act on it
		if (last_byte) begin
			state   <= has_result ? ST_RESULT : ST_IDLE;
			res0_q  <= res0_now;
			res1_q  <= i_drive_stat[int_drv].pcn;
			res_two <= (cmd_now == CMD_SENSE_INT) && int_any;

			if (cmd_now == CMD_SPECIFY)
				o_srt <= param0[BYTE_W-1 -: SRT_W];  // step rate in the upper nibble

			if (cmd_now == CMD_SEEK || cmd_now == CMD_RECAL)
				o_seek_req.valid <= 1'b1;
			o_seek_req.recal <= (cmd_now == CMD_RECAL);
			o_seek_req.drive <= (cmd_now == CMD_SEEK) ? param0[DRV_W-1:0] : drv;
			o_seek_req.cyl   <= (cmd_now == CMD_SEEK) ? i_host_wr.data : '0;

			if (cmd_now == CMD_SENSE_INT)
				o_int_clear[int_drv] <= int_any;
		end
	end
end

// credits come back only for bytes that were pushed
a_credit_max: assert property (@(posedge i_clk_sys) disable iff (i_reset)
	credit <= CRD_W'(FIFO_DEPTH));

a_push_credit: assert property (@(posedge i_clk_sys) disable iff (i_reset)
	o_result.valid |-> $past(credit) != '0);

endmodule

/* fdc_top.sv */
`timescale 1ns/1ps

module fdc_top
	import fdc_pkg::*;
#(
	parameter int CYCLES_PER_MS = 4000
) (
	input  logic                  i_clk_sys,
	input  logic                  i_reset,
	input  logic                  i_a0,
	input  logic                  i_rd_n,
	input  logic                  i_wr_n,
	input  fdc_byte_t             i_din,
	output fdc_byte_t             o_dout,
	input  logic [NUM_DRIVES-1:0] i_ready,
	input  logic                  i_wp,
	input  logic [NUM_DRIVES-1:0] i_two_sided
);

host_wr_t                     host_wr;
logic                         rd_pulse;
fdc_byte_t                    fifo_head;
logic                         fifo_not_empty;
logic                         busy;
seek_req_t                    seek_req;
logic [NUM_DRIVES-1:0]        int_clear;
logic [SRT_W-1:0]             srt;
drive_stat_t [NUM_DRIVES-1:0] drive_stat;
logic [NUM_DRIVES-1:0]        seeking;
result_t                      result;
logic                         credit;

for (genvar g = 0; g < NUM_DRIVES; g++) begin : g_seek_bits
	assign seeking[g] = drive_stat[g].seeking;
end

fdc_host_port u_host_port (
	.i_clk_sys        (i_clk_sys),
	.i_reset          (i_reset),
	.i_a0             (i_a0),
	.i_rd_n           (i_rd_n),
	.i_wr_n           (i_wr_n),
	.i_din            (i_din),
	.o_dout           (o_dout),
	.o_host_wr        (host_wr),
	.o_rd_pulse       (rd_pulse),
	.i_fifo_head      (fifo_head),
	.i_fifo_not_empty (fifo_not_empty),
	.i_busy           (busy),
	.i_seeking        (seeking)
);

// drive ready reaches the sequencer through the drive status
fdc_sequencer u_sequencer (
	.i_clk_sys    (i_clk_sys),
	.i_reset      (i_reset),
	.i_host_wr    (host_wr),
	.o_seek_req   (seek_req),
	.o_int_clear  (int_clear),
	.o_srt        (srt),
	.i_drive_stat (drive_stat),
	.i_wp         (i_wp),
	.i_two_sided  (i_two_sided),
	.o_result     (result),
	.i_credit     (credit),
	.o_busy       (busy)
);

fdc_seek_unit #(
	.CYCLES_PER_MS (CYCLES_PER_MS)
) u_seek_unit (
	.i_clk_sys    (i_clk_sys),
	.i_reset      (i_reset),
	.i_seek_req   (seek_req),
	.i_int_clear  (int_clear),
	.i_srt        (srt),
	.i_ready      (i_ready),
	.o_drive_stat (drive_stat)
);

fdc_result_fifo u_result_fifo (
	.i_clk_sys   (i_clk_sys),
	.i_reset     (i_reset),
	.i_push      (result),
	.i_pop       (rd_pulse),
	.o_head      (fifo_head),
	.o_not_empty (fifo_not_empty),
	.o_credit    (credit)
);

endmodule

/* files.f */
fdc_pkg.sv
fdc_host_port.sv
fdc_sequencer.sv
fdc_seek_unit.sv
fdc_result_fifo.sv
fdc_top.sv
tb_fdc.sv

/* tb_fdc.sv */
`timescale 1ns/1ps

module tb_fdc
	import fdc_pkg::*;
();

logic                  clk_sys;
logic                  reset;
logic                  a0;
logic                  rd_n;
logic                  wr_n;
fdc_byte_t             din;
fdc_byte_t             dout;
logic [NUM_DRIVES-1:0] ready;
logic                  wp;
logic [NUM_DRIVES-1:0] two_sided;

logic [31:0] lcg_state;
fdc_byte_t   seek_tgt;  // drive 0 target and later its cylinder
fdc_byte_t   old_cyl1;  // drive 1 never moves

initial begin
	clk_sys = 1'b0;
	forever #4 clk_sys = ~clk_sys;
end

fdc_top #(
	.CYCLES_PER_MS (4)
) dut (
	.i_clk_sys   (clk_sys),
	.i_reset     (reset),
	.i_a0        (a0),
	.i_rd_n      (rd_n),
	.i_wr_n      (wr_n),
	.i_din       (din),
	.o_dout      (dout),
	.i_ready     (ready),
	.i_wp        (wp),
	.i_two_sided (two_sided)
);

// ====================
// expected values
function automatic logic [31:0] lcg_next(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic fdc_byte_t st0_expect(input logic ok, input logic drive);
	fdc_byte_t b;
	b    = ok ? 8'h20 : 8'hE8;  // seek end or abnormal end plus seek end
	b[0] = drive;
	return b;
endfunction

function automatic fdc_byte_t st3_expect(input logic wp_in, input logic rdy, input logic trk0,
		input logic two_side, input logic head, input logic drive);
	return {1'b0, wp_in & rdy, rdy, trk0, two_side, head, 1'b0, drive};
endfunction

// ====================
// bus access
task automatic stop_run();
	$display("test failed");
	$fatal(1, "simulation stopped at the first error");
endtask

task automatic check_byte(input string name, input fdc_byte_t got, input fdc_byte_t exp);
	assert (got === exp) else begin
		$display("Error at %0d ns: %s is 0x%02h, expected 0x%02h", $time, name, got, exp);
		stop_run();
	end
endtask

task automatic bus_read(input logic addr, output fdc_byte_t value);
	@(posedge clk_sys);
	a0   <= addr;
	rd_n <= 1'b0;
	repeat (3) @(posedge clk_sys);  // edge found and dout registered
	@(negedge clk_sys);
	value = dout;
	@(posedge clk_sys);
	rd_n <= 1'b1;
	repeat (2) @(posedge clk_sys);
endtask

task automatic read_status(output fdc_byte_t value);
	bus_read(1'b0, value);
endtask

task automatic read_data(output fdc_byte_t value);
	bus_read(1'b1, value);
endtask

task automatic wait_status(input fdc_byte_t mask, input fdc_byte_t value, input int limit,
		input string what);
	fdc_byte_t msr;
	int        polls;
	polls = 0;
	read_status(msr);
	while ((msr & mask) != value) begin
		polls++;
		assert (polls < limit) else begin
			$display("timeout while waiting for %s", what);
			stop_run();
		end
		read_status(msr);
	end
endtask

task automatic write_cmd(input fdc_byte_t value);
	wait_status(8'hC0, 8'h80, 50, "RQM before a command byte");
	@(posedge clk_sys);
	a0   <= 1'b1;
	din  <= value;
	wr_n <= 1'b0;
	repeat (3) @(posedge clk_sys);  // held until the byte reaches the sequencer
	wr_n <= 1'b1;
	repeat (2) @(posedge clk_sys);
endtask

task automatic read_result(input string name, input fdc_byte_t exp);
	fdc_byte_t got;
	wait_status(8'hC0, 8'hC0, 50, {"result byte ", name});
	read_data(got);
	check_byte(name, got, exp);
endtask

task automatic sense_int(input string name, input fdc_byte_t st0, input fdc_byte_t cyl);
	write_cmd({3'b000, CMD_SENSE_INT});
	read_result({name, " st0"}, st0);
	read_result({name, " cylinder"}, cyl);
endtask

// ====================
// directed tests
task automatic reset_defaults();
	fdc_byte_t b;
	read_status(b);
	check_byte("msr after reset", b, 8'h80);
	read_data(b);
	check_byte("dout on empty fifo", b, 8'hFF);
endtask

task automatic invalid_command();
	fdc_byte_t b;
	write_cmd(8'h1F);  // no command uses this code
	read_result("invalid command", 8'h80);
	read_status(b);
	check_byte("msr after invalid result", b, 8'h80);
endtask

task automatic seek_in_range();
	fdc_byte_t b;
	write_cmd({3'b000, CMD_SPECIFY});
	write_cmd({4'd14, 4'hF});  // srt 14 gives one step every 2 ms
	write_cmd(8'h02);
	lcg_state = lcg_next(lcg_state);
	seek_tgt  = fdc_byte_t'(10 + int'(lcg_state[23:8] % 16'd70));
	write_cmd({3'b000, CMD_SEEK});
	write_cmd(8'h00);
	write_cmd(seek_tgt);
	wait_status(8'h01, 8'h01, 20, "drive 0 seek start");
	wait_status(8'h01, 8'h00, 500, "drive 0 seek end");
	sense_int("seek drive 0", st0_expect(1'b1, 1'b0), seek_tgt);
	write_cmd({3'b000, CMD_SENSE_INT});
	read_result("no interrupt pending", 8'h80);
	read_status(b);
	check_byte("msr after single byte", b, 8'h80);
endtask

task automatic seek_out_of_range();
	fdc_byte_t bad_tgt;
	lcg_state = lcg_next(lcg_state);
	bad_tgt   = fdc_byte_t'(MAX_CYL + int'(lcg_state[23:8] % 16'd100));
	write_cmd({3'b000, CMD_SEEK});
	write_cmd(8'h01);
	write_cmd(bad_tgt);
	sense_int("rejected seek drive 1", st0_expect(1'b0, 1'b1), old_cyl1);
endtask

task automatic recal_and_sense_drive();
	write_cmd({3'b000, CMD_RECAL});
	write_cmd(8'h00);
	wait_status(8'h01, 8'h01, 20, "recalibrate start");
	wait_status(8'h01, 8'h00, 500, "recalibrate end");
	sense_int("recalibrate drive 0", st0_expect(1'b1, 1'b0), 8'h00);

	write_cmd({3'b000, CMD_SENSE_DRIVE});
	write_cmd(8'h04);  // head 1 on drive 0
	read_result("st3 drive 0",
		st3_expect(wp, ready[0], 1'b1, two_sided[0], 1'b1, 1'b0));
	write_cmd({3'b000, CMD_SENSE_DRIVE});
	write_cmd(8'h01);
	read_result("st3 drive 1",
		st3_expect(wp, ready[1], 1'b1, two_sided[1], 1'b0, 1'b1));
endtask

// ====================
initial begin
	reset     <= 1'b1;
	a0        <= 1'b0;
	rd_n      <= 1'b1;
	wr_n      <= 1'b1;
	din       <= '0;
	ready     <= 2'b11;
	wp        <= 1'b1;
	two_sided <= 2'b01;  // only drive 0 has two sides
	lcg_state = 32'h7c96;
	old_cyl1  = 8'h00;
	repeat (3) @(posedge clk_sys);
	reset <= 1'b0;
	repeat (2) @(posedge clk_sys);

	reset_defaults();
	invalid_command();
	seek_in_range();
	seek_out_of_range();
	recal_and_sense_drive();

	$display("test passed");
	$finish;
end

endmodule
